//--- source/floppy_pkg.sv
/*
  Shared address map, widths and encodings for the floppy peripheral fabric.
  Port offsets are byte offsets inside the I/O window and only the low byte
  of the CPU address is compared against them.
  TICK_DIV is kept short for simulation; hardware would divide down to 100 Hz.
*/
`default_nettype none

package floppy_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int BUF_AW    = 10;
    localparam int BUF_BYTES = 1 << BUF_AW;

    typedef logic [15:0]       cpu_addr_t;
    typedef logic [15:0]       cpu_word_t;
    typedef logic [7:0]        byte_t;
    typedef logic [BUF_AW-1:0] buf_addr_t;

    ////////////////////////////////////////
    // address map
    ////////////////////////////////////////
    localparam cpu_addr_t IO_BASE  = 16'hFF00;
    localparam cpu_addr_t IO_LIMIT = 16'hFFEF;
    localparam cpu_addr_t BUF_BASE = 16'hD000;

    // offsets inside the i/o window
    localparam byte_t PORT_MMCA        = 8'd0;
    localparam byte_t PORT_JOY         = 8'd2;
    localparam byte_t PORT_TXD         = 8'd4;
    localparam byte_t PORT_CTL         = 8'd6;
    localparam byte_t PORT_TMR1        = 8'd8;
    localparam byte_t PORT_TMR2        = 8'd10;
    localparam byte_t PORT_CPU_REQUEST = 8'd12;
    localparam byte_t PORT_CPU_STATUS  = 8'd14;
    localparam byte_t PORT_OSD_COMMAND = 8'd22;

    // timer prescaler, clocks per tick
    localparam int TICK_DIV = 16;
    localparam int TICK_W   = $clog2(TICK_DIV);

    // console sender states
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_WAIT_READY,
        UART_WAIT_BUSY,
        UART_WAIT_DONE
    } uart_state_t;

endpackage

`default_nettype wire

//--- source/io_port_regs.sv
/*
  I/O port window $FF00..$FFEF. Register writes use lane 0 only, the high
  byte of a port write is ignored. Read data comes one cycle after the read
  strobe and is zero in every other cycle, so it can be ORed on the bus.
*/
`timescale 1ns/1ps
`default_nettype none

module io_port_regs
(
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire floppy_pkg::cpu_addr_t i_cpu_addr,
    input  wire                   i_cpu_rd,
    input  wire [1:0]             i_cpu_wr,
    input  wire floppy_pkg::cpu_word_t i_cpu_wdata,
    input  wire [5:0]             i_keys,
    input  wire floppy_pkg::byte_t i_ctl_request,
    input  wire                   i_uart_busy,
    input  wire                   i_uart_idle,
    input  wire floppy_pkg::byte_t i_tmr1_q,
    input  wire floppy_pkg::byte_t i_tmr2_q,
    output floppy_pkg::cpu_word_t o_rdata,
    output logic                  o_sd_cs_n,
    output floppy_pkg::byte_t     o_osd_command,
    output floppy_pkg::byte_t     o_ctl_status,
    output logic                  o_txd_load,
    output logic                  o_tmr1_load,
    output logic                  o_tmr2_load,
    output floppy_pkg::byte_t     o_wdata_byte
);
    import floppy_pkg::*;

    logic      io_sel;
    logic      io_wr;
    byte_t     port;
    cpu_word_t rd_mux;
    cpu_word_t rd_data_q;
    logic      rd_sel_q;

    ////////////////////////////////////////
    // window decode
    ////////////////////////////////////////
    assign io_sel       = (i_cpu_addr >= IO_BASE) && (i_cpu_addr <= IO_LIMIT);
    assign io_wr        = io_sel & i_cpu_wr[0];
    assign port         = i_cpu_addr[7:0];
    assign o_wdata_byte = i_cpu_wdata[7:0];

    // strobes for the blocks beside us
    assign o_txd_load  = io_wr & (port == PORT_TXD);
    assign o_tmr1_load = io_wr & (port == PORT_TMR1);
    assign o_tmr2_load = io_wr & (port == PORT_TMR2);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            o_sd_cs_n     <= 1'b1;
            o_osd_command <= '0;
            o_ctl_status  <= '0;
        end
        else if (io_wr)
        begin
            case (port)
                PORT_MMCA:        o_sd_cs_n     <= i_cpu_wdata[0];
                PORT_OSD_COMMAND: o_osd_command <= o_wdata_byte;
                PORT_CPU_STATUS:  o_ctl_status  <= o_wdata_byte;
                default:          ;
            endcase
        end
    end

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////
    always_comb
    begin
        rd_mux = '0;
        case (port)
            PORT_MMCA:        rd_mux[0]   = o_sd_cs_n;
            PORT_JOY:         rd_mux[5:0] = i_keys;
            // bit 1 set while a byte is still on its way out
            PORT_CTL:         rd_mux[1:0] = {~i_uart_idle, i_uart_busy};
            PORT_TMR1:        rd_mux[7:0] = i_tmr1_q;
            PORT_TMR2:        rd_mux[7:0] = i_tmr2_q;
            PORT_CPU_REQUEST: rd_mux[7:0] = i_ctl_request;
            PORT_CPU_STATUS:  rd_mux[7:0] = o_ctl_status;
            PORT_OSD_COMMAND: rd_mux[7:0] = o_osd_command;
            default:          ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        rd_data_q <= rd_mux;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_sel_q <= 1'b0;
        else
            rd_sel_q <= io_sel & i_cpu_rd;
    end

    assign o_rdata = rd_sel_q ? rd_data_q : '0;

    // uart and timers never see a load in the same cycle
    a_single_load: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({o_txd_load, o_tmr1_load, o_tmr2_load}));

endmodule

`default_nettype wire

//--- source/console_tx.sv
/*
  Console byte sender. Hands one byte to an external transmitter with a
  send/busy exchange. A new load restarts the exchange with the new byte,
  even in the middle of a send. o_idle is high once the exchange is over.
*/
`timescale 1ns/1ps
`default_nettype none

module console_tx
(
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    i_load,
    input  wire floppy_pkg::byte_t i_data,
    input  wire                    i_busy,
    output logic                   o_send,
    output floppy_pkg::byte_t      o_data,
    output logic                   o_idle
);
    import floppy_pkg::*;

    uart_state_t state;

    always_ff @(posedge clk)
    begin
        if (i_load)
            o_data <= i_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state  <= UART_IDLE;
            o_send <= 1'b0;
        end
        else if (i_load)
        begin
            state  <= UART_WAIT_READY;
            o_send <= 1'b0;
        end
        else
        begin
            case (state)
                // wait for the transmitter to be free
                UART_WAIT_READY:
                    if (!i_busy)
                    begin
                        o_send <= 1'b1;
                        state  <= UART_WAIT_BUSY;
                    end
                // held until it takes the byte
                UART_WAIT_BUSY:
                    if (i_busy)
                    begin
                        o_send <= 1'b0;
                        state  <= UART_WAIT_DONE;
                    end
                UART_WAIT_DONE:
                    if (!i_busy)
                        state <= UART_IDLE;
                default: ;
            endcase
        end
    end

    assign o_idle = (state == UART_IDLE);

    a_no_send_idle: assert property (@(posedge clk) disable iff (!reset_n)
        (state == UART_IDLE) |-> !o_send);

endmodule

`default_nettype wire

//--- source/tick_timer.sv
/*
  Loadable 8-bit down counter. Counts once every TICK_DIV clocks and holds
  at zero. A load restarts the prescaler, so the first tick comes a full
  period after the load.
*/
`timescale 1ns/1ps
`default_nettype none

module tick_timer
(
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    i_load,
    input  wire floppy_pkg::byte_t i_data,
    output floppy_pkg::byte_t      o_q
);
    import floppy_pkg::*;

    logic [TICK_W-1:0] pre;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pre <= '0;
            o_q <= '0;
        end
        else if (i_load)
        begin
            pre <= '0;
            o_q <= i_data;
        end
        else if (pre == TICK_W'(TICK_DIV - 1))
        begin
            pre <= '0;
            if (o_q != '0)
                o_q <= o_q - 8'd1;
        end
        else
            pre <= pre + 1'b1;
    end

    // only a load can move the count off zero
    a_hold_zero: assert property (@(posedge clk) disable iff (!reset_n)
        (o_q == '0 && !i_load) |=> (o_q == '0));

endmodule

`default_nettype wire

//--- source/sector_buffer.sv
/*
  1 KB sector buffer, two 512x8 lanes. Even bytes live in the low lane and
  odd bytes in the high lane. The controller byte port always wins: a CPU
  access in the same cycle is dropped and its read returns zero.
  Both ports have one cycle of read latency. Contents are not cleared.
*/
`timescale 1ns/1ps
`default_nettype none

module sector_buffer
(
    input  wire                        clk,
    input  wire                        i_cpu_sel,
    input  wire                        i_cpu_rd,
    input  wire [1:0]                  i_cpu_wr,
    input  wire floppy_pkg::buf_addr_t i_cpu_addr,
    input  wire floppy_pkg::cpu_word_t i_cpu_wdata,
    input  wire floppy_pkg::buf_addr_t i_buf_addr,
    input  wire                        i_buf_rd,
    input  wire                        i_buf_wr,
    input  wire floppy_pkg::byte_t     i_buf_wdata,
    output floppy_pkg::cpu_word_t      o_cpu_rdata,
    output floppy_pkg::byte_t          o_buf_rdata
);
    import floppy_pkg::*;

    byte_t mem_lo [BUF_BYTES/2];
    byte_t mem_hi [BUF_BYTES/2];

    logic              buf_act;
    logic              cpu_ok;
    logic [BUF_AW-2:0] row;
    logic              we_lo;
    logic              we_hi;
    byte_t             di_lo;
    byte_t             di_hi;
    byte_t             do_lo;
    byte_t             do_hi;
    logic              cpu_rd_q;
    logic              buf_hi_q;

    ////////////////////////////////////////
    // port arbitration
    ////////////////////////////////////////
    assign buf_act = i_buf_rd | i_buf_wr;
    assign cpu_ok  = i_cpu_sel & ~buf_act;
    assign row     = buf_act ? i_buf_addr[BUF_AW-1:1] : i_cpu_addr[BUF_AW-1:1];

    // controller picks one lane by address bit 0
    assign we_lo = (i_buf_wr & ~i_buf_addr[0]) | (cpu_ok & i_cpu_wr[0]);
    assign we_hi = (i_buf_wr & i_buf_addr[0]) | (cpu_ok & i_cpu_wr[1]);
    assign di_lo = i_buf_wr ? i_buf_wdata : i_cpu_wdata[7:0];
    assign di_hi = i_buf_wr ? i_buf_wdata : i_cpu_wdata[15:8];

    always_ff @(posedge clk)
    begin
        if (we_lo)
            mem_lo[row] <= di_lo;
        if (we_hi)
            mem_hi[row] <= di_hi;
        do_lo <= mem_lo[row];
        do_hi <= mem_hi[row];
    end

    ////////////////////////////////////////
    // read return
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        cpu_rd_q <= cpu_ok & i_cpu_rd;
        buf_hi_q <= i_buf_addr[0];
    end

    assign o_cpu_rdata = cpu_rd_q ? {do_hi, do_lo} : '0;
    assign o_buf_rdata = buf_hi_q ? do_hi : do_lo;

endmodule

`default_nettype wire

//--- source/floppy_periph_top.sv
/*
  Peripheral fabric of the floppy emulator. The CPU side is a plain memory
  bus: byte address, read strobe, two lane write strobes. Every source
  returns zero outside its read cycle and the results are ORed together.
*/
`timescale 1ns/1ps
`default_nettype none

module floppy_periph_top
(
    input  wire                        clk,
    input  wire                        reset_n,
    // cpu bus
    input  wire floppy_pkg::cpu_addr_t i_cpu_addr,
    input  wire                        i_cpu_rd,
    input  wire [1:0]                  i_cpu_wr,
    input  wire floppy_pkg::cpu_word_t i_cpu_wdata,
    output floppy_pkg::cpu_word_t      o_cpu_rdata,
    // controller byte port
    input  wire floppy_pkg::buf_addr_t i_buf_addr,
    input  wire                        i_buf_rd,
    input  wire                        i_buf_wr,
    input  wire floppy_pkg::byte_t     i_buf_wdata,
    output floppy_pkg::byte_t          o_buf_rdata,
    // controller status exchange
    input  wire floppy_pkg::byte_t     i_ctl_request,
    output floppy_pkg::byte_t          o_ctl_status,
    input  wire [5:0]                  i_keys,
    output logic                       o_sd_cs_n,
    output floppy_pkg::byte_t          o_osd_command,
    // console uart
    output logic                       o_uart_send,
    output floppy_pkg::byte_t          o_uart_data,
    input  wire                        i_uart_busy
);
    import floppy_pkg::*;

    cpu_word_t io_rdata;
    cpu_word_t buf_rdata;
    byte_t     wdata_byte;
    byte_t     tmr1_q;
    byte_t     tmr2_q;
    logic      txd_load;
    logic      tmr1_load;
    logic      tmr2_load;
    logic      uart_idle;
    logic      buf_sel;

    // $d000..$d3ff
    assign buf_sel = (i_cpu_addr >= BUF_BASE) && (i_cpu_addr < BUF_BASE + BUF_BYTES);

    io_port_regs u_io_port_regs
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_cpu_addr    (i_cpu_addr),
        .i_cpu_rd      (i_cpu_rd),
        .i_cpu_wr      (i_cpu_wr),
        .i_cpu_wdata   (i_cpu_wdata),
        .i_keys        (i_keys),
        .i_ctl_request (i_ctl_request),
        .i_uart_busy   (i_uart_busy),
        .i_uart_idle   (uart_idle),
        .i_tmr1_q      (tmr1_q),
        .i_tmr2_q      (tmr2_q),
        .o_rdata       (io_rdata),
        .o_sd_cs_n     (o_sd_cs_n),
        .o_osd_command (o_osd_command),
        .o_ctl_status  (o_ctl_status),
        .o_txd_load    (txd_load),
        .o_tmr1_load   (tmr1_load),
        .o_tmr2_load   (tmr2_load),
        .o_wdata_byte  (wdata_byte)
    );

    console_tx u_console_tx
    (
        .clk     (clk),
        .reset_n (reset_n),
        .i_load  (txd_load),
        .i_data  (wdata_byte),
        .i_busy  (i_uart_busy),
        .o_send  (o_uart_send),
        .o_data  (o_uart_data),
        .o_idle  (uart_idle)
    );

    tick_timer tmr1
    (
        .clk     (clk),
        .reset_n (reset_n),
        .i_load  (tmr1_load),
        .i_data  (wdata_byte),
        .o_q     (tmr1_q)
    );

    tick_timer tmr2
    (
        .clk     (clk),
        .reset_n (reset_n),
        .i_load  (tmr2_load),
        .i_data  (wdata_byte),
        .o_q     (tmr2_q)
    );

    sector_buffer u_sector_buffer
    (
        .clk         (clk),
        .i_cpu_sel   (buf_sel),
        .i_cpu_rd    (i_cpu_rd),
        .i_cpu_wr    (i_cpu_wr),
        .i_cpu_addr  (i_cpu_addr[BUF_AW-1:0]),
        .i_cpu_wdata (i_cpu_wdata),
        .i_buf_addr  (i_buf_addr),
        .i_buf_rd    (i_buf_rd),
        .i_buf_wr    (i_buf_wr),
        .i_buf_wdata (i_buf_wdata),
        .o_cpu_rdata (buf_rdata),
        .o_buf_rdata (o_buf_rdata)
    );

    assign o_cpu_rdata = io_rdata | buf_rdata;

endmodule

`default_nettype wire

//--- tb/tb_floppy_periph.sv
/*
  Testbench for the floppy peripheral fabric. Plays the CPU and the disk
  controller and answers the console sender with a fixed busy pulse.
  Inputs change 1 ns after the rising edge. Buffer data is pseudo-random
  from a fixed seed. Only addresses written in this run are read back.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_floppy_periph;
    import floppy_pkg::*;

    localparam logic [3:0] OP_WR   = 4'd0;
    localparam logic [3:0] OP_RD   = 4'd1;
    localparam logic [3:0] OP_CS   = 4'd2;
    localparam logic [3:0] OP_OSD  = 4'd3;
    localparam logic [3:0] OP_STAT = 4'd4;

    localparam logic [5:0] KEY_VALUE = 6'h2a;
    localparam byte_t      REQ_VALUE = 8'h5c;
    localparam int         ROWS      = 19;

    // op, port, write data, lanes, expected
    localparam logic [45:0] PORT_TABLE [ROWS] = '{
        {OP_WR,   PORT_MMCA,        16'h0000, 2'b01, 16'h0000},
        {OP_CS,   PORT_MMCA,        16'h0000, 2'b00, 16'h0000},
        {OP_RD,   PORT_MMCA,        16'h0000, 2'b00, 16'h0000},
        {OP_WR,   PORT_MMCA,        16'hff01, 2'b11, 16'h0000},
        {OP_CS,   PORT_MMCA,        16'h0000, 2'b00, 16'h0001},
        {OP_RD,   PORT_MMCA,        16'h0000, 2'b00, 16'h0001},
        {OP_WR,   PORT_OSD_COMMAND, 16'h12a5, 2'b11, 16'h0000},
        {OP_OSD,  PORT_OSD_COMMAND, 16'h0000, 2'b00, 16'h00a5},
        {OP_RD,   PORT_OSD_COMMAND, 16'h0000, 2'b00, 16'h00a5},
        {OP_WR,   PORT_CPU_STATUS,  16'h003c, 2'b01, 16'h0000},
        {OP_STAT, PORT_CPU_STATUS,  16'h0000, 2'b00, 16'h003c},
        {OP_RD,   PORT_CPU_STATUS,  16'h0000, 2'b00, 16'h003c},
        // high lane alone must not touch a port register
        {OP_WR,   PORT_CPU_STATUS,  16'h0099, 2'b10, 16'h0000},
        {OP_RD,   PORT_CPU_STATUS,  16'h0000, 2'b00, 16'h003c},
        {OP_RD,   PORT_JOY,         16'h0000, 2'b00, {10'd0, KEY_VALUE}},
        {OP_RD,   PORT_CPU_REQUEST, 16'h0000, 2'b00, {8'd0, REQ_VALUE}},
        {OP_RD,   8'h20,            16'h0000, 2'b00, 16'h0000},
        {OP_RD,   8'hee,            16'h0000, 2'b00, 16'h0000},
        {OP_RD,   8'h01,            16'h0000, 2'b00, 16'h0000}
    };

    logic       clk;
    logic       reset_n;
    cpu_addr_t  i_cpu_addr;
    logic       i_cpu_rd;
    logic [1:0] i_cpu_wr;
    cpu_word_t  i_cpu_wdata;
    cpu_word_t  o_cpu_rdata;
    buf_addr_t  i_buf_addr;
    logic       i_buf_rd;
    logic       i_buf_wr;
    byte_t      i_buf_wdata;
    byte_t      o_buf_rdata;
    byte_t      i_ctl_request;
    byte_t      o_ctl_status;
    logic [5:0] i_keys;
    logic       o_sd_cs_n;
    byte_t      o_osd_command;
    logic       o_uart_send;
    byte_t      o_uart_data;
    logic       i_uart_busy;

    byte_t       model [BUF_BYTES];
    logic [31:0] rng = 32'hb701;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    logic        prev_send = 1'b0;
    logic        prev_busy = 1'b0;

    floppy_periph_top i_floppy_periph_top
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_cpu_addr    (i_cpu_addr),
        .i_cpu_rd      (i_cpu_rd),
        .i_cpu_wr      (i_cpu_wr),
        .i_cpu_wdata   (i_cpu_wdata),
        .o_cpu_rdata   (o_cpu_rdata),
        .i_buf_addr    (i_buf_addr),
        .i_buf_rd      (i_buf_rd),
        .i_buf_wr      (i_buf_wr),
        .i_buf_wdata   (i_buf_wdata),
        .o_buf_rdata   (o_buf_rdata),
        .i_ctl_request (i_ctl_request),
        .o_ctl_status  (o_ctl_status),
        .i_keys        (i_keys),
        .o_sd_cs_n     (o_sd_cs_n),
        .o_osd_command (o_osd_command),
        .o_uart_send   (o_uart_send),
        .o_uart_data   (o_uart_data),
        .i_uart_busy   (i_uart_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cycles <= cycles + 1;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %t: %s", $time, msg);
    endtask

    task automatic expect_value(input string what, input cpu_word_t got, input cpu_word_t want);
        checks++;
        if (got !== want)
            report_error($sformatf("%s: got %h, expected %h", what, got, want));
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: no %s within the allowed cycles", what);
        $display("test failed");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("[%0d] %s: ok", tests, name);
        else
            $display("[%0d] %s: %0d error(s)", tests, name, errors - errors_before);
    endtask

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////
    task automatic cpu_write(input cpu_addr_t addr, input cpu_word_t data, input logic [1:0] lanes);
        next_cycle();
        i_cpu_addr = addr;
        i_cpu_wdata = data;
        i_cpu_wr = lanes;
        next_cycle();
        i_cpu_wr = 2'b00;
    endtask

    // data is valid in the cycle after the strobe
    task automatic cpu_read(input cpu_addr_t addr, output cpu_word_t data);
        next_cycle();
        i_cpu_addr = addr;
        i_cpu_rd = 1'b1;
        next_cycle();
        i_cpu_rd = 1'b0;
        data = o_cpu_rdata;
    endtask

    task automatic buf_write(input buf_addr_t addr, input byte_t data);
        next_cycle();
        i_buf_addr = addr;
        i_buf_wdata = data;
        i_buf_wr = 1'b1;
        next_cycle();
        i_buf_wr = 1'b0;
    endtask

    task automatic buf_read(input buf_addr_t addr, output byte_t data);
        next_cycle();
        i_buf_addr = addr;
        i_buf_rd = 1'b1;
        next_cycle();
        i_buf_rd = 1'b0;
        data = o_buf_rdata;
    endtask

    // both ports write in one cycle and both read in the next
    task automatic collide(input buf_addr_t cpu_a, input cpu_word_t cpu_w, input buf_addr_t ctl_a,
                           input byte_t ctl_b, output cpu_word_t cpu_q, output byte_t ctl_q);
        next_cycle();
        i_cpu_addr = BUF_BASE + cpu_a;
        i_cpu_wdata = cpu_w;
        i_cpu_wr = 2'b11;
        i_buf_addr = ctl_a;
        i_buf_wdata = ctl_b;
        i_buf_wr = 1'b1;
        next_cycle();
        i_cpu_wr = 2'b00;
        i_buf_wr = 1'b0;
        i_cpu_rd = 1'b1;
        i_buf_rd = 1'b1;
        next_cycle();
        i_cpu_rd = 1'b0;
        i_buf_rd = 1'b0;
        cpu_q = o_cpu_rdata;
        ctl_q = o_buf_rdata;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 30)
                abort_on_timeout(what);
        end
        while (i_uart_busy !== level);
    endtask

    task automatic poll_timer(input byte_t port, input int start, input int limit,
                              inout byte_t last, inout logic done);
        cpu_word_t d;
        cpu_read(IO_BASE + port, d);
        checks++;
        if (d[7:0] > last)
            report_error($sformatf("timer %0d went up from %0d to %0d", port, last, d[7:0]));
        last = d[7:0];
        if (d[7:0] == 8'd0 && !done)
        begin
            done = 1'b1;
            checks++;
            if (cycles - start > limit)
                report_error($sformatf("timer %0d took %0d cycles", port, cycles - start));
        end
    endtask

    ////////////////////////////////////////
    // uart side
    ////////////////////////////////////////
    // busy comes two cycles after send and lasts five
    initial
    begin
        i_uart_busy = 1'b0;
        forever
        begin
            next_cycle();
            if (o_uart_send)
            begin
                repeat (2) next_cycle();
                i_uart_busy = 1'b1;
                repeat (5) next_cycle();
                i_uart_busy = 1'b0;
            end
        end
    end

    // send may only rise on a free line and must drop once busy is seen
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (!prev_send && o_uart_send && prev_busy)
                report_error("o_uart_send rose while busy was high");
            if (prev_send && o_uart_send && prev_busy)
                report_error("o_uart_send still high after busy rose");
            if (prev_send && !o_uart_send && !prev_busy)
                report_error("o_uart_send dropped before busy rose");
        end
        prev_send = o_uart_send;
        prev_busy = i_uart_busy;
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        logic [45:0] row;
        byte_t       port;
        cpu_word_t   want;
        cpu_word_t   d;
        byte_t       b;
        byte_t       last1;
        byte_t       last2;
        logic        done1;
        logic        done2;
        buf_addr_t   a;
        buf_addr_t   c;
        byte_t       tx_bytes [3];
        int          i;
        int          n;
        int          mark;
        int          t1_start;
        int          t2_start;

        $timeformat(-9, 0, " ns", 0);
        tx_bytes = '{8'h41, 8'h0d, 8'h7e};
        reset_n = 1'b0;
        i_cpu_addr = '0;
        i_cpu_rd = 1'b0;
        i_cpu_wr = 2'b00;
        i_cpu_wdata = '0;
        i_buf_addr = '0;
        i_buf_rd = 1'b0;
        i_buf_wr = 1'b0;
        i_buf_wdata = '0;
        i_ctl_request = REQ_VALUE;
        i_keys = KEY_VALUE;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        mark = errors;
        expect_value("o_sd_cs_n", {15'd0, o_sd_cs_n}, 16'h0001);
        expect_value("o_osd_command", {8'd0, o_osd_command}, 16'h0000);
        expect_value("o_ctl_status", {8'd0, o_ctl_status}, 16'h0000);
        expect_value("o_uart_send", {15'd0, o_uart_send}, 16'h0000);
        cpu_read(IO_BASE + PORT_TMR1, d);
        expect_value("tmr1 after reset", d, 16'h0000);
        cpu_read(IO_BASE + PORT_TMR2, d);
        expect_value("tmr2 after reset", d, 16'h0000);
        cpu_read(IO_BASE + PORT_CTL, d);
        expect_value("ctl after reset", d, 16'h0000);
        finish_test("reset values", mark);

        mark = errors;
        for (i = 0; i < ROWS; i++)
        begin
            row = PORT_TABLE[i];
            port = row[41:34];
            want = row[15:0];
            case (row[45:42])
                OP_WR: cpu_write(IO_BASE + port, row[33:18], row[17:16]);
                OP_RD:
                begin
                    cpu_read(IO_BASE + port, d);
                    expect_value($sformatf("row %0d port %0d", i, port), d, want);
                end
                OP_CS:   expect_value("o_sd_cs_n", {15'd0, o_sd_cs_n}, want);
                OP_OSD:  expect_value("o_osd_command", {8'd0, o_osd_command}, want);
                OP_STAT: expect_value("o_ctl_status", {8'd0, o_ctl_status}, want);
                default: report_error("bad table row");
            endcase
        end
        finish_test("port table", mark);

        mark = errors;
        // cpu words come back to the controller as low then high byte
        for (i = 0; i < 8; i++)
        begin
            rng = xorshift(rng);
            a = {rng[8:0], 1'b0};
            cpu_write(BUF_BASE + a, rng[31:16], 2'b11);
            model[a] = rng[23:16];
            model[a + 10'd1] = rng[31:24];
            buf_read(a, b);
            expect_value("controller low byte", {8'd0, b}, {8'd0, model[a]});
            buf_read(a + 10'd1, b);
            expect_value("controller high byte", {8'd0, b}, {8'd0, model[a + 10'd1]});
        end
        for (i = 0; i < 8; i++)
        begin
            rng = xorshift(rng);
            a = {rng[9:1], 1'b0};
            buf_write(a, rng[15:8]);
            model[a] = rng[15:8];
            buf_write(a + 10'd1, rng[23:16]);
            model[a + 10'd1] = rng[23:16];
            cpu_read(BUF_BASE + a, d);
            expect_value("cpu word", d, {model[a + 10'd1], model[a]});
        end
        // a high lane write leaves the low byte alone
        rng = xorshift(rng);
        cpu_write(BUF_BASE + a, rng[15:0], 2'b10);
        model[a + 10'd1] = rng[15:8];
        cpu_read(BUF_BASE + a, d);
        expect_value("single lane write", d, {model[a + 10'd1], model[a]});
        // the controller wins and the cpu write and read are dropped
        c = a ^ 10'h200;
        collide(a, ~{model[a + 10'd1], model[a]}, c, rng[31:24], d, b);
        model[c] = rng[31:24];
        expect_value("cpu read in collision", d, 16'h0000);
        expect_value("controller read in collision", {8'd0, b}, {8'd0, model[c]});
        cpu_read(BUF_BASE + a, d);
        expect_value("cpu write lost in collision", d, {model[a + 10'd1], model[a]});
        finish_test("sector buffer", mark);

        mark = errors;
        for (i = 0; i < 3; i++)
        begin
            if (i != 1)
                cpu_write(IO_BASE + PORT_TXD, {8'd0, tx_bytes[i]}, 2'b01);
            expect_value("o_uart_data", {8'd0, o_uart_data}, {8'd0, tx_bytes[i]});
            cpu_read(IO_BASE + PORT_CTL, d);
            expect_value("ctl pending bit", {15'd0, d[1]}, 16'h0001);
            wait_busy(1'b1, "busy rising");
            // second byte goes in while the line is still busy
            if (i == 0)
                cpu_write(IO_BASE + PORT_TXD, {8'd0, tx_bytes[1]}, 2'b01);
            wait_busy(1'b0, "busy falling");
            if (i != 0)
            begin
                cpu_read(IO_BASE + PORT_CTL, d);
                expect_value("ctl pending bit after send", {15'd0, d[1]}, 16'h0000);
            end
        end
        finish_test("console send", mark);

        mark = errors;
        cpu_write(IO_BASE + PORT_TMR1, 16'd5, 2'b01);
        t1_start = cycles;
        cpu_write(IO_BASE + PORT_TMR2, 16'd2, 2'b01);
        t2_start = cycles;
        last1 = 8'd5;
        last2 = 8'd2;
        done1 = 1'b0;
        done2 = 1'b0;
        n = 0;
        while (!(done1 && done2))
        begin
            poll_timer(PORT_TMR1, t1_start, 6 * TICK_DIV + 8, last1, done1);
            poll_timer(PORT_TMR2, t2_start, 3 * TICK_DIV + 8, last2, done2);
            n++;
            if (n > 100)
                abort_on_timeout("timer reaching zero");
        end
        // hold at zero over a couple of tick periods
        for (i = 0; i < 8; i++)
        begin
            cpu_read(IO_BASE + PORT_TMR1, d);
            expect_value("tmr1 held at zero", d, 16'h0000);
            cpu_read(IO_BASE + PORT_TMR2, d);
            expect_value("tmr2 held at zero", d, 16'h0000);
        end
        finish_test("timers", mark);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/floppy_pkg.sv
source/io_port_regs.sv
source/console_tx.sv
source/tick_timer.sv
source/sector_buffer.sv
source/floppy_periph_top.sv
tb/tb_floppy_periph.sv

//--- Makefile
# Verilator flow for the floppy peripheral fabric

TOP := tb_floppy_periph

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module floppy_periph_top

# the run counts as passed only if the pass line shows up
sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o vsim
	@out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
